/* project.f */
rtl/sam_pkg.sv
rtl/tick_divider.sv
rtl/port_regs.sv
rtl/mem_map.sv
rtl/vox_dac.sv
rtl/midi_tx.sv
rtl/sam_asic_top.sv
testbench/sam_asic_tb.sv

/* Makefile */
# Verilator build and run for the ASIC port block testbench

VERILATOR ?= verilator
TOP       ?= sam_asic_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^TEST PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/sam_asic_tb.sv */
/*
 * Table-driven testbench for the ASIC port block and memory mapper.
 * Each table row is one bus operation with its expected response, a
 * monitor checks every MIDI frame and the status port on the side.
 */

`timescale 1ns/1ns

module sam_asic_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	localparam int TICK_DIV     = 4;
	localparam int FRAME_TICKS  = 20;
	localparam int INT_TICKS    = 15;

	localparam logic [2:0] OP_WR      = 3'd0;
	localparam logic [2:0] OP_WR_HOLD = 3'd1;
	localparam logic [2:0] OP_RD      = 3'd2;
	localparam logic [2:0] OP_MEM     = 3'd3;
	localparam logic [2:0] OP_VOX     = 3'd4;
	localparam logic [2:0] OP_BORDER  = 3'd5;
	localparam logic [2:0] OP_MIDI    = 3'd6;

	typedef struct packed {
		logic [2:0]  op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] exp;
	} row_t;

	logic              clk_sys = 1'b0;
	logic              reset;
	sam_pkg::cpu_bus_t bus;
	sam_pkg::mem_req_t mem;
	logic [7:0]        io_rdata;
	logic [3:0]        border_color;
	logic              ear;
	logic [7:0]        vox_l;
	logic [7:0]        vox_r;
	logic              midi_out;
	logic              int_midi;

	row_t rows[$];
	bit   table_ready = 1'b0;
	int   frames_done = 0;
	int   high_cnt = 0;
	int   int_cnt = 0;

	sam_asic_top #(
		.TICK_DIV         (TICK_DIV),
		.MIDI_FRAME_TICKS (FRAME_TICKS)
	) dut_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.mem          (mem),
		.io_rdata     (io_rdata),
		.border_color (border_color),
		.ear          (ear),
		.vox_l        (vox_l),
		.vox_r        (vox_r),
		.midi_out     (midi_out),
		.int_midi     (int_midi)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ========================================================================
	// Checker and bus operations
	// ========================================================================

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// io_we high for two cycles, then low for one
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge clk_sys);
		bus <= {8'h00, port, data, 1'b1, 1'b0};
		@(posedge clk_sys);
		@(posedge clk_sys);
		bus.io_we <= 1'b0;
	endtask

	// Data changes while io_we stays high, only the first byte may land
	task automatic hold_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge clk_sys);
		bus <= {8'h00, port, data, 1'b1, 1'b0};
		@(posedge clk_sys);
		bus.wdata <= ~data;
		repeat (3) @(posedge clk_sys);
		bus.io_we <= 1'b0;
	endtask

	task automatic io_read(input logic [7:0] port, input logic [31:0] exp);
		@(posedge clk_sys);
		bus <= {8'h00, port, 8'h00, 1'b0, 1'b0};
		@(negedge clk_sys);
		check("port readback", 32'(io_rdata), exp);
	endtask

	task automatic mem_probe(input logic [15:0] addr, input logic wr, input logic [31:0] exp);
		@(posedge clk_sys);
		bus <= {addr, 8'h00, 1'b0, wr};
		@(negedge clk_sys);
		check("memory request", {5'd0, mem}, exp);
	endtask

	task automatic send_midi(input logic [7:0] data, input int frames);
		int target;
		target = frames_done + frames;
		io_write(sam_pkg::PORT_MIDI, data);
		// Second write lands while the first frame is still running
		if (frames > 1) begin
			while (!midi_out) @(negedge clk_sys);
			io_write(sam_pkg::PORT_MIDI, ~data);
		end
		@(posedge clk_sys);
		bus <= {8'h00, sam_pkg::PORT_STATUS, 8'h00, 1'b0, 1'b0};
		while (frames_done < target) @(posedge clk_sys);
		repeat (2 * TICK_DIV) @(posedge clk_sys);
		@(negedge clk_sys);
		check("midi_out idle after frames", 32'(midi_out), 32'd0);
	endtask

	task automatic apply_row(input row_t r);
		case (r.op)
			OP_WR:      io_write(r.addr[7:0], r.data);
			OP_WR_HOLD: hold_write(r.addr[7:0], r.data);
			OP_RD:      io_read(r.addr[7:0], r.exp);
			OP_MEM:     mem_probe(r.addr, r.data[0], r.exp);
			OP_VOX: begin
				@(negedge clk_sys);
				check("vox_l and vox_r", {16'd0, vox_l, vox_r}, r.exp);
			end
			OP_BORDER: begin
				@(negedge clk_sys);
				check("ear and border_color", {27'd0, ear, border_color}, r.exp);
			end
			OP_MIDI:    send_midi(r.data, int'(r.exp));
			default: begin
				$display("Unknown operation %0d in the stimulus table", r.op);
				$display("TEST FAIL");
				$fatal(1, "bad table row");
			end
		endcase
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================

	task automatic add_row(input logic [2:0] op, input logic [15:0] addr,
			input logic [7:0] data, input logic [31:0] exp);
		rows.push_back({op, addr, data, exp});
	endtask

	// Expected memory request from bank (addr 24..14), offset, rom_sel, we
	function automatic logic [31:0] mreq(input logic [10:0] bank, input logic [13:0] off,
			input logic rom, input logic we);
		return {5'd0, bank, off, rom, we};
	endfunction

	task automatic build_table();
		add_row(OP_RD, 16'h00F9, 8'h00, 32'h0000_00FF);
		add_row(OP_RD, 16'h00FA, 8'h00, 32'h0000_0000);
		add_row(OP_RD, 16'h00FB, 8'h00, 32'h0000_0000);
		add_row(OP_VOX, 16'h0000, 8'h00, 32'h0000_0000);
		add_row(OP_BORDER, 16'h0000, 8'h00, 32'h0000_0000);
		add_row(OP_WR, 16'h00FA, 8'hA5, 32'h0);
		add_row(OP_RD, 16'h00FA, 8'h00, 32'h0000_00A5);
		add_row(OP_WR, 16'h00FB, 8'h63, 32'h0);
		add_row(OP_RD, 16'h00FB, 8'h00, 32'h0000_0063);
		add_row(OP_WR, 16'h00FE, 8'h25, 32'h0);
		add_row(OP_BORDER, 16'h0000, 8'h00, 32'h0000_000D);
		add_row(OP_WR, 16'h00FE, 8'h12, 32'h0);
		add_row(OP_BORDER, 16'h0000, 8'h00, 32'h0000_0012);
		add_row(OP_WR_HOLD, 16'h00FA, 8'h1E, 32'h0);
		add_row(OP_RD, 16'h00FA, 8'h00, 32'h0000_001E);
		// ROM 0 on, ROM 1 off, LMPR page 30, HMPR page 3
		add_row(OP_MEM, 16'h1234, 8'h01, mreq(11'd32, 14'h1234, 1'b1, 1'b0));
		add_row(OP_MEM, 16'h5678, 8'h01, mreq(11'd31, 14'h1678, 1'b0, 1'b1));
		add_row(OP_MEM, 16'h9ABC, 8'h00, mreq(11'd3, 14'h1ABC, 1'b0, 1'b0));
		add_row(OP_MEM, 16'hC001, 8'h01, mreq(11'd4, 14'h0001, 1'b0, 1'b1));
		// Write protect, ROM 0 off, ROM 1 on, page 9
		add_row(OP_WR, 16'h00FA, 8'hE9, 32'h0);
		add_row(OP_MEM, 16'h0100, 8'h01, mreq(11'd9, 14'h0100, 1'b0, 1'b0));
		add_row(OP_MEM, 16'h4100, 8'h01, mreq(11'd10, 14'h0100, 1'b0, 1'b1));
		add_row(OP_MEM, 16'hC200, 8'h01, mreq(11'd33, 14'h0200, 1'b1, 1'b0));
		add_row(OP_MEM, 16'h8200, 8'h01, mreq(11'd3, 14'h0200, 1'b0, 1'b1));
		// External RAM in the upper half
		add_row(OP_WR, 16'h0080, 8'h05, 32'h0);
		add_row(OP_WR, 16'h0081, 8'h9A, 32'h0);
		add_row(OP_WR, 16'h00FB, 8'h82, 32'h0);
		add_row(OP_RD, 16'h00FB, 8'h00, 32'h0000_0082);
		add_row(OP_WR, 16'h00FA, 8'h29, 32'h0);
		add_row(OP_MEM, 16'h8010, 8'h01, mreq(11'd69, 14'h0010, 1'b0, 1'b1));
		add_row(OP_MEM, 16'hFFFF, 8'h01, mreq(11'd218, 14'h3FFF, 1'b0, 1'b1));
		add_row(OP_MEM, 16'h4000, 8'h01, mreq(11'd10, 14'h0000, 1'b0, 1'b1));
		add_row(OP_MEM, 16'h0000, 8'h01, mreq(11'd9, 14'h0000, 1'b0, 1'b1));
		// DAC latch and strobe edges
		add_row(OP_WR, 16'h00E8, 8'h3C, 32'h0);
		add_row(OP_WR, 16'h00E9, 8'h01, 32'h0);
		add_row(OP_VOX, 16'h0000, 8'h00, 32'h0000_3C00);
		add_row(OP_WR, 16'h00E8, 8'hC3, 32'h0);
		add_row(OP_WR, 16'h00E9, 8'h01, 32'h0);
		add_row(OP_VOX, 16'h0000, 8'h00, 32'h0000_3C00);
		add_row(OP_WR, 16'h00E9, 8'h00, 32'h0);
		add_row(OP_VOX, 16'h0000, 8'h00, 32'h0000_3CC3);
		add_row(OP_WR, 16'h00E8, 8'h5A, 32'h0);
		add_row(OP_WR, 16'h00E9, 8'hFE, 32'h0);
		add_row(OP_VOX, 16'h0000, 8'h00, 32'h0000_3CC3);
		// Expected value of a MIDI row is its frame count
		add_row(OP_MIDI, 16'h00FD, 8'h90, 32'd1);
		add_row(OP_MIDI, 16'h00FD, 8'h45, 32'd2);
		add_row(OP_RD, 16'h00F9, 8'h00, 32'h0000_00FF);
	endtask

	// ========================================================================
	// MIDI frame monitor, watchdog and main sequence
	// ========================================================================

	always @(negedge clk_sys) begin
		if (!reset) begin
			if (bus.addr[7:0] == sam_pkg::PORT_STATUS)
				check("status readback", 32'(io_rdata),
					int_midi ? 32'h0000_00EF : 32'h0000_00FF);
			check("int_midi outside a frame", 32'(int_midi & ~midi_out), 32'd0);
			if (midi_out) begin
				high_cnt++;
				if (int_midi)
					int_cnt++;
				else
					check("int_midi fell before frame end", int_cnt, 32'd0);
			end else if (high_cnt != 0) begin
				check("midi_out high cycles", high_cnt, FRAME_TICKS * TICK_DIV);
				check("int_midi high cycles", int_cnt, INT_TICKS * TICK_DIV);
				frames_done++;
				high_cnt = 0;
				int_cnt = 0;
			end
		end
	end

	initial begin
		int midi_count;
		int limit_cycles;
		midi_count = 0;
		wait (table_ready);
		foreach (rows[i])
			if (rows[i].op == OP_MIDI)
				midi_count += int'(rows[i].exp);
		// Generous slot per row, one extra tick per frame to start
		limit_cycles = 2 * (RESET_CYCLES + 16 * rows.size()
			+ midi_count * (FRAME_TICKS + 2) * TICK_DIV);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		reset = 1'b1;
		bus = '0;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check("midi_out after reset", 32'(midi_out), 32'd0);
		check("int_midi after reset", 32'(int_midi), 32'd0);
		foreach (rows[i])
			apply_row(rows[i]);
		$display("TEST PASS");
		$finish;
	end

endmodule

/* rtl/sam_asic_top.sv */
/*
 * Top of the ASIC port and memory mapping block.
 * Takes the CPU bus and returns the memory request, port readback,
 * border, DAC and MIDI outputs.
 */

`timescale 1ns/1ns

module sam_asic_top #(
	parameter int TICK_DIV         = 96,
	parameter int MIDI_FRAME_TICKS = 320
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  sam_pkg::cpu_bus_t bus,
	output sam_pkg::mem_req_t mem,
	output logic [7:0]        io_rdata,
	output logic [3:0]        border_color,
	output logic              ear,
	output logic [7:0]        vox_l,
	output logic [7:0]        vox_r,
	output logic              midi_out,
	output logic              int_midi
);

	sam_pkg::lmpr_t      lmpr;
	sam_pkg::hmpr_t      hmpr;
	sam_pkg::ext_pages_t ext;
	logic                midi_wr;
	logic                lptd_wr;
	logic                lpts_wr;
	logic                tick;

	// ========================================================================
	// Ports and paging
	// ========================================================================

	port_regs port_regs_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.int_midi     (int_midi),
		.lmpr         (lmpr),
		.hmpr         (hmpr),
		.ext          (ext),
		.border_color (border_color),
		.ear          (ear),
		.midi_wr      (midi_wr),
		.lptd_wr      (lptd_wr),
		.lpts_wr      (lpts_wr),
		.io_rdata     (io_rdata)
	);

	mem_map mem_map_i (
		.bus  (bus),
		.lmpr (lmpr),
		.hmpr (hmpr),
		.ext  (ext),
		.mem  (mem)
	);

	// ========================================================================
	// Audio and MIDI
	// ========================================================================

	vox_dac vox_dac_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.lptd_wr (lptd_wr),
		.lpts_wr (lpts_wr),
		.vox_l   (vox_l),
		.vox_r   (vox_r)
	);

	tick_divider #(.DIV(TICK_DIV)) tick_divider_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.tick    (tick)
	);

	midi_tx #(.FRAME_TICKS(MIDI_FRAME_TICKS)) midi_tx_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.tick     (tick),
		.midi_wr  (midi_wr),
		.midi_out (midi_out),
		.int_midi (int_midi)
	);

endmodule

/* rtl/midi_tx.sv */
/*
 * MIDI transmit frame timer.
 * A port write arms it, the next idle tick starts a frame of FRAME_TICKS
 * ticks, and the interrupt is raised for the final 15 ticks.
 */

`timescale 1ns/1ns

module midi_tx #(
	parameter int FRAME_TICKS = 320
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic tick,
	input  logic midi_wr,
	output logic midi_out,
	output logic int_midi
);

	localparam int CW = $clog2(FRAME_TICKS);

	typedef enum logic {
		IDLE,
		SENDING
	} state_t;

	state_t        state;
	logic          pending;
	logic [CW-1:0] remain;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= IDLE;
			pending  <= 1'b0;
			remain   <= '0;
			midi_out <= 1'b0;
			int_midi <= 1'b0;
		end else begin
			if (tick) begin
				case (state)
					IDLE: begin
						if (pending) begin
							state    <= SENDING;
							pending  <= 1'b0;
							remain   <= CW'(FRAME_TICKS - 1);
							midi_out <= 1'b1;
						end
					end
					SENDING: begin
						if (remain == '0) begin
							state    <= IDLE;
							midi_out <= 1'b0;
							int_midi <= 1'b0;
						end else begin
							remain <= remain - 1'b1;
							// 15 ticks left including this one
							if (remain == CW'(15))
								int_midi <= 1'b1;
						end
					end
					default: state <= IDLE;
				endcase
			end
			// A write arriving mid-frame waits for the next one
			if (midi_wr)
				pending <= 1'b1;
		end
	end

endmodule

/* rtl/vox_dac.sv */
/*
 * Parallel-port DAC pair driven through the LPT data and strobe ports.
 * A strobe rise loads the left channel, a strobe fall loads the right.
 */

`timescale 1ns/1ns

module vox_dac (
	input  logic              clk_sys,
	input  logic              reset,
	input  sam_pkg::cpu_bus_t bus,
	input  logic              lptd_wr,
	input  logic              lpts_wr,
	output logic [7:0]        vox_l,
	output logic [7:0]        vox_r
);

	logic [7:0] data_latch;
	logic       stb_q;

	always_ff @(posedge clk_sys) begin
		if (lptd_wr)
			data_latch <= bus.wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l <= 8'd0;
			vox_r <= 8'd0;
			stb_q <= 1'b0;
		end else if (lpts_wr) begin
			// Compare against the last strobe level written
			if (~stb_q & bus.wdata[0])
				vox_l <= data_latch;
			if (stb_q & ~bus.wdata[0])
				vox_r <= data_latch;
			stb_q <= bus.wdata[0];
		end
	end

endmodule

/* rtl/mem_map.sv */
/*
 * CPU address to 25-bit memory address translation.
 * Applies the LMPR/HMPR paging, the two ROM windows, external RAM
 * pages and write protect of the lowest section.
 */

`timescale 1ns/1ns

module mem_map (
	input  sam_pkg::cpu_bus_t   bus,
	input  sam_pkg::lmpr_t      lmpr,
	input  sam_pkg::hmpr_t      hmpr,
	input  sam_pkg::ext_pages_t ext,
	output sam_pkg::mem_req_t   mem
);

	logic [1:0]  section;
	logic [13:0] offset;
	logic        rom0_sel;
	logic        rom1_sel;
	logic        ext_sel;
	logic        wp_hit;
	logic [8:0]  ext_page;
	logic [4:0]  ram_page;

	assign section = bus.addr[15:14];
	assign offset  = bus.addr[13:0];

	assign rom0_sel = ~lmpr.rom0_off && (section == 2'd0);
	assign rom1_sel = lmpr.rom1_on && (section == 2'd3);
	assign ext_sel  = hmpr.ext_ram & bus.addr[15];
	assign wp_hit   = lmpr.wp && (section == 2'd0);

	// Section 2 takes ext C, section 3 ext D
	assign ext_page = sam_pkg::EXT_BASE + {1'b0, bus.addr[14] ? ext.d : ext.c};

	// Odd sections use the following page, wrapping inside 32
	assign ram_page = (bus.addr[15] ? hmpr.page : lmpr.page) + {4'd0, bus.addr[14]};

	always_comb begin
		if (rom0_sel || rom1_sel)
			mem.addr = {5'd0, sam_pkg::ROM_BANK, bus.addr[15], offset};
		else if (ext_sel)
			mem.addr = {2'd0, ext_page, offset};
		else
			mem.addr = {6'd0, ram_page, offset};
	end

	assign mem.rom_sel = rom0_sel | rom1_sel;
	assign mem.we      = bus.mem_wr & ~(rom0_sel | rom1_sel) & ~wp_hit;

endmodule

/* rtl/port_regs.sv */
/*
 * ASIC port write decode and readback.
 * Holds the memory paging, border and external RAM page registers and
 * issues one-cycle strobes for the MIDI and parallel-port DAC writes.
 */

`timescale 1ns/1ns

module port_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  sam_pkg::cpu_bus_t     bus,
	input  logic                  int_midi,
	output sam_pkg::lmpr_t        lmpr,
	output sam_pkg::hmpr_t        hmpr,
	output sam_pkg::ext_pages_t   ext,
	output logic [3:0]            border_color,
	output logic                  ear,
	output logic                  midi_wr,
	output logic                  lptd_wr,
	output logic                  lpts_wr,
	output logic [7:0]            io_rdata
);

	logic [7:0] port_sel;
	logic       io_we_q;
	logic       we_edge;

	assign port_sel = bus.addr[7:0];

	// A held write level only counts once, on its rising edge
	assign we_edge = bus.io_we & ~io_we_q;

	// ========================================================================
	// Register writes
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_we_q      <= 1'b0;
			lmpr         <= '0;
			hmpr         <= '0;
			ext          <= '0;
			border_color <= 4'd0;
			ear          <= 1'b0;
		end else begin
			io_we_q <= bus.io_we;
			if (we_edge) begin
				case (port_sel)
					sam_pkg::PORT_LMPR: lmpr <= bus.wdata;
					sam_pkg::PORT_HMPR: hmpr <= bus.wdata;
					sam_pkg::PORT_EXT_C: ext.c <= bus.wdata;
					sam_pkg::PORT_EXT_D: ext.d <= bus.wdata;
					sam_pkg::PORT_BORDER: begin
						// Colour is bits 5 and 2..0, the speaker bit sits at 4
						border_color <= {bus.wdata[5], bus.wdata[2:0]};
						ear          <= bus.wdata[4];
					end
					default: ;
				endcase
			end
		end
	end

	// Strobes share the write edge so the data byte is still on the bus
	assign midi_wr = we_edge && (port_sel == sam_pkg::PORT_MIDI);
	assign lptd_wr = we_edge && (port_sel == sam_pkg::PORT_LPTD);
	assign lpts_wr = we_edge && (port_sel == sam_pkg::PORT_LPTS);

	// ========================================================================
	// Readback
	// ========================================================================

	always_comb begin
		case (port_sel)
			sam_pkg::PORT_LMPR:   io_rdata = lmpr;
			sam_pkg::PORT_HMPR:   io_rdata = hmpr;
			// Interrupt flags are active low, only MIDI is wired here
			sam_pkg::PORT_STATUS: io_rdata = {3'b111, ~int_midi, 4'b1111};
			default:              io_rdata = 8'hFF;
		endcase
	end

endmodule

/* rtl/tick_divider.sv */
/*
 * Divides clk_sys down to a single-cycle tick, one every DIV cycles.
 * Used as the 1 MHz time base of the MIDI transmitter.
 */

`timescale 1ns/1ns

module tick_divider #(
	parameter int DIV = 96
) (
	input  logic clk_sys,
	input  logic reset,
	output logic tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	// Free-running, wraps at DIV-1
	always_ff @(posedge clk_sys) begin
		if (reset || cnt == CW'(DIV - 1))
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	assign tick = (cnt == '0);

endmodule

/* rtl/sam_pkg.sv */
/*
 * Shared definitions for the ASIC port block and memory mapper.
 * Port numbers, ROM and external RAM bases, register layouts and bus types.
 */

package sam_pkg;

	// Low address byte of each decoded I/O port
	localparam logic [7:0] PORT_STATUS = 8'd249;
	localparam logic [7:0] PORT_LMPR   = 8'd250;
	localparam logic [7:0] PORT_HMPR   = 8'd251;
	localparam logic [7:0] PORT_BORDER = 8'd254;
	localparam logic [7:0] PORT_MIDI   = 8'd253;
	localparam logic [7:0] PORT_LPTD   = 8'd232;
	localparam logic [7:0] PORT_LPTS   = 8'd233;
	localparam logic [7:0] PORT_EXT_C  = 8'd128;
	localparam logic [7:0] PORT_EXT_D  = 8'd129;

	// ROM sits at upper address 16, external RAM pages start above 64
	localparam logic [4:0] ROM_BANK = 5'd16;
	localparam logic [8:0] EXT_BASE = 9'd64;

	typedef struct packed {
		logic       wp;
		logic       rom1_on;
		logic       rom0_off;
		logic [4:0] page;
	} lmpr_t;

	typedef struct packed {
		logic       ext_ram;
		logic [1:0] mode3_hi;
		logic [4:0] page;
	} hmpr_t;

	typedef struct packed {
		logic [7:0] c;
		logic [7:0] d;
	} ext_pages_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        io_we;
		logic        mem_wr;
	} cpu_bus_t;

	typedef struct packed {
		logic [24:0] addr;
		logic        rom_sel;
		logic        we;
	} mem_req_t;

endpackage
